//--- hw/rv_decode_pkg.sv
// Shared RV32I decode constants and micro-op types, imported by every decode stage module
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and function codes
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [OPCODE_W-1:0] OPCODE_LOAD    = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPCODE_MISCMEM = 7'b0001111; // FENCE family
  localparam logic [OPCODE_W-1:0] OPCODE_OPIMM   = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPCODE_AUIPC   = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPCODE_STORE   = 7'b0100011;
  localparam logic [OPCODE_W-1:0] OPCODE_OP      = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPCODE_LUI     = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OPCODE_SYSTEM  = 7'b1110011;

  localparam logic [2:0] FUNCT3_SHIFT_L = 3'b001; // SLL(I)
  localparam logic [2:0] FUNCT3_SHIFT_R = 3'b101; // SRL(I) and SRA(I)

  // Whole-word SYSTEM encodings
  localparam logic [XLEN-1:0] ECALL_INSTR  = 32'h0000_0073;
  localparam logic [XLEN-1:0] EBREAK_INSTR = 32'h0010_0073;
  localparam logic [XLEN-1:0] WFI_INSTR    = 32'h1050_0073;

  ////////////////////////////////////////////////////////////////////////////
  // Control field types
  ////////////////////////////////////////////////////////////////////////////

  // ALU select is {instr[30], funct3} or {1'b0, funct3}
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_OP_ADD = 4'b0000;

  // LSU control is {store, funct3}
  typedef logic [3:0] lsu_ctrl_t;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_ISH,  // 5-bit shift amount
    IMM_S,
    IMM_U
  } imm_fmt_t;

  // Micro-op handed to ALU, register file and LSU
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    alu_op_t               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;
    logic                  use_pc;     // Operand A is the PC
    logic                  wb;         // Register writeback
    logic                  lsu_valid;
    lsu_ctrl_t             lsu_ctrl;
  } uop_t;

  // Trap events for the control unit
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebreak;
  } trap_t;

endpackage

//--- hw/imm_gen.sv
// Immediate generator: builds the sign-extended I, shift, S or U immediate of an instruction
`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
  input  rv_decode_pkg::imm_fmt_t        fmt_i,
  output logic [rv_decode_pkg::XLEN-1:0] imm_o
);

  import rv_decode_pkg::*;

  logic sign;

  assign sign = instr_i[31]; // Sign bit sits at 31 for every format

  always_comb begin
    case (fmt_i)
      IMM_I: begin
        imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
      end
      IMM_ISH: begin
        // Shift amount only, never sign extended
        imm_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};
      end
      IMM_S: begin
        imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
      end
      IMM_U: begin
        imm_o = {instr_i[31:12], 12'b0};  // Upper 20 bits, low part zero
      end
      default: begin
        imm_o = '0;  // IMM_NONE
      end
    endcase
  end

endmodule

//--- hw/instr_classifier.sv
// Combinational RV32I decode of one instruction word into a micro-op and trap flags
`timescale 1ns/1ps

module instr_classifier (
  input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
  input  logic [rv_decode_pkg::XLEN-1:0] pc_i,
  output rv_decode_pkg::uop_t            uop_o,
  output rv_decode_pkg::trap_t           trap_o
);

  import rv_decode_pkg::*;

  logic [OPCODE_W-1:0]   opcode;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  is_shift;
  imm_fmt_t              fmt;
  logic [XLEN-1:0]       imm;
  uop_t                  uop_c;   // Everything but the immediate

  // Instruction fields
  assign opcode   = instr_i[6:0];
  assign rd       = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign rs1      = instr_i[19:15];
  assign rs2      = instr_i[24:20];
  assign funct7   = instr_i[31:25];
  assign is_shift = (funct3 == FUNCT3_SHIFT_L) || (funct3 == FUNCT3_SHIFT_R);

  imm_gen imm_gen_inst (
    .instr_i (instr_i),
    .fmt_i   (fmt),
    .imm_o   (imm)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Per-opcode decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    uop_c        = '0;
    uop_c.pc     = pc_i;
    uop_c.alu_op = ALU_OP_ADD;
    trap_o       = '0;
    fmt          = IMM_NONE;

    case (opcode)
      OPCODE_OP: begin
        uop_c.alu_op  = {instr_i[30], funct3};
        uop_c.rs1     = rs1;
        uop_c.rs2     = rs2;
        uop_c.use_rs1 = 1'b1;
        uop_c.use_rs2 = 1'b1;
        uop_c.rd      = rd;
        uop_c.wb      = 1'b1;
      end
      OPCODE_OPIMM: begin
        uop_c.rs1     = rs1;
        uop_c.use_rs1 = 1'b1;
        uop_c.use_imm = 1'b1;
        uop_c.rd      = rd;
        uop_c.wb      = 1'b1;
        if (!is_shift) begin
          fmt          = IMM_I;
          uop_c.alu_op = {1'b0, funct3};
        end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
          fmt          = IMM_ISH;
          uop_c.alu_op = {instr_i[30], funct3};  // Bit 30 picks SRA
        end else begin
          trap_o.illegal = 1'b1;
        end
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        fmt           = IMM_U;
        uop_c.use_imm = 1'b1;
        uop_c.use_pc  = opcode[5] ? 1'b0 : 1'b1;  // Only AUIPC adds the PC
        uop_c.rd      = rd;
        uop_c.wb      = 1'b1;
      end
      OPCODE_LOAD: begin
        fmt             = IMM_I;
        uop_c.rs1       = rs1;
        uop_c.use_rs1   = 1'b1;
        uop_c.use_imm   = 1'b1;
        uop_c.rd        = rd;
        uop_c.wb        = 1'b1;
        uop_c.lsu_valid = 1'b1;
        uop_c.lsu_ctrl  = {opcode[5], funct3};
      end
      OPCODE_STORE: begin
        fmt             = IMM_S;
        uop_c.rs1       = rs1;
        uop_c.rs2       = rs2;
        uop_c.use_rs1   = 1'b1;
        uop_c.use_rs2   = 1'b1;
        uop_c.use_imm   = 1'b1;
        uop_c.lsu_valid = 1'b1;
        uop_c.lsu_ctrl  = {opcode[5], funct3};
      end
      OPCODE_MISCMEM: begin
        // Fences issue as an empty micro-op
      end
      OPCODE_SYSTEM: begin
        if (instr_i == ECALL_INSTR) begin
          trap_o.ecall = 1'b1;
        end else if (instr_i == EBREAK_INSTR) begin
          trap_o.ebreak = 1'b1;
        end else if (instr_i != WFI_INSTR) begin
          trap_o.illegal = 1'b1; // CSR ops and MRET included
        end
      end
      default: begin
        trap_o.illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    uop_o     = uop_c;
    uop_o.imm = imm;
  end

endmodule

//--- hw/hazard_ctrl.sv
// Read-after-write check against the last issued destination; drives ready and accept
`timescale 1ns/1ps

module hazard_ctrl (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 instr_valid_i,
  input  rv_decode_pkg::uop_t  uop_i,
  input  rv_decode_pkg::trap_t trap_i,
  output logic                 ready_o,
  output logic                 accept_o
);

  import rv_decode_pkg::*;

  logic [REG_ADDR_W-1:0] last_rd;
  logic                  rs1_hit;
  logic                  rs2_hit;
  logic                  hazard;
  logic                  writes_rd;

  // x0 never matches since last_rd stays zero for it
  assign rs1_hit = uop_i.use_rs1 && (uop_i.rs1 == last_rd);
  assign rs2_hit = uop_i.use_rs2 && (uop_i.rs2 == last_rd);
  assign hazard  = instr_valid_i && (last_rd != '0) && (rs1_hit || rs2_hit);

  assign ready_o  = ~hazard;
  assign accept_o = instr_valid_i & ready_o;

  // Only an issued micro-op with a real destination arms the check
  assign writes_rd = accept_o && !(|trap_i) && uop_i.wb && (uop_i.rd != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Last destination register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd <= '0;
    end else if (writes_rd) begin
      last_rd <= uop_i.rd;
    end else begin
      last_rd <= '0;   // Bubble, idle, trap or store
    end
  end

endmodule

//--- hw/pipe_reg.sv
// One-cycle output register with a valid flag, shared by any packed payload type
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic valid_i,
  input  T     data_i,
  output logic valid_o,
  output T     data_o
);

  // Valid flag
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload, holds its last value between beats
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

//--- hw/rv_decoder_top.sv
// RV32I decode stage top: classify, hazard check and register micro-op or trap output
`timescale 1ns/1ps

module rv_decoder_top (
  input  logic                           clk_i,
  input  logic                           rstn_i,
  input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
  input  logic [rv_decode_pkg::XLEN-1:0] pc_i,
  input  logic                           instr_valid_i,
  output logic                           ready_o,
  output logic                           uop_valid_o,
  output rv_decode_pkg::uop_t            uop_o,
  output logic                           trap_valid_o,
  output rv_decode_pkg::trap_t           trap_o
);

  import rv_decode_pkg::*;

  uop_t  uop;
  trap_t trap;
  logic  accept;
  logic  is_trap;

  instr_classifier instr_classifier_inst (
    .instr_i (instr_i),
    .pc_i    (pc_i),
    .uop_o   (uop),
    .trap_o  (trap)
  );

  hazard_ctrl hazard_ctrl_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .uop_i         (uop),
    .trap_i        (trap),
    .ready_o       (ready_o),
    .accept_o      (accept)
  );

  assign is_trap = |trap;  // A trapping word issues no micro-op

  pipe_reg #(.T(uop_t)) uop_reg_inst (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .valid_i (accept & ~is_trap),
    .data_i  (uop),
    .valid_o (uop_valid_o),
    .data_o  (uop_o)
  );

  pipe_reg #(.T(trap_t)) trap_reg_inst (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .valid_i (accept & is_trap),
    .data_i  (trap),
    .valid_o (trap_valid_o),
    .data_o  (trap_o)
  );

endmodule

//--- tb/decode_model.svh
// Reference model of the decode stage, included inside the testbench module after the package import
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic logic [31:0] sign_ext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// Trap flags straight from the ISA encodings
function automatic trap_t trap_for(input logic [31:0] instr);
  trap_t      t;
  logic [2:0] f3;
  logic [6:0] f7;
  t  = '0;
  f3 = instr[14:12];
  f7 = instr[31:25];
  case (instr[6:0])
    OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC, OPCODE_LOAD, OPCODE_STORE, OPCODE_MISCMEM: ;
    OPCODE_OPIMM: begin
      // SLLI, SRLI and SRAI only allow two funct7 values
      t.illegal = (f3 == 3'b001 || f3 == 3'b101) && !(f7 == 7'h00 || f7 == 7'h20);
    end
    OPCODE_SYSTEM: begin
      t.ecall   = (instr == 32'h0000_0073);
      t.ebreak  = (instr == 32'h0010_0073);
      t.illegal = !(t.ecall || t.ebreak || instr == 32'h1050_0073);  // WFI is a no-op
    end
    default: t.illegal = 1'b1;
  endcase
  return t;
endfunction

// Micro-op fields per instruction class
function automatic uop_t uop_for(input logic [31:0] instr, input logic [31:0] pc);
  uop_t       u;
  logic [2:0] f3;
  logic       shift;
  u     = '0;
  u.pc  = pc;
  f3    = instr[14:12];
  shift = (f3 == 3'b001) || (f3 == 3'b101);
  case (instr[6:0])
    OPCODE_OP: begin
      u.alu_op  = {instr[30], f3};
      {u.rs1, u.rs2, u.rd} = {instr[19:15], instr[24:20], instr[11:7]};
      {u.use_rs1, u.use_rs2, u.wb} = 3'b111;
    end
    OPCODE_OPIMM: begin
      u.alu_op  = shift ? {instr[30], f3} : {1'b0, f3};
      u.imm     = shift ? {27'b0, instr[24:20]} : sign_ext12(instr[31:20]);
      {u.rs1, u.rd} = {instr[19:15], instr[11:7]};
      {u.use_rs1, u.use_imm, u.wb} = 3'b111;
    end
    OPCODE_LUI, OPCODE_AUIPC: begin
      u.imm    = {instr[31:12], 12'h000};
      u.use_pc = (instr[6:0] == OPCODE_AUIPC);
      u.rd     = instr[11:7];
      {u.use_imm, u.wb} = 2'b11;
    end
    OPCODE_LOAD: begin
      u.imm      = sign_ext12(instr[31:20]);
      {u.rs1, u.rd} = {instr[19:15], instr[11:7]};
      {u.use_rs1, u.use_imm, u.wb, u.lsu_valid} = 4'b1111;
      u.lsu_ctrl = {1'b0, f3};
    end
    OPCODE_STORE: begin
      u.imm      = sign_ext12({instr[31:25], instr[11:7]});
      {u.rs1, u.rs2} = {instr[19:15], instr[24:20]};
      {u.use_rs1, u.use_rs2, u.use_imm, u.lsu_valid} = 4'b1111;
      u.lsu_ctrl = {1'b1, f3};
    end
    default: ;  // Fences, SYSTEM and unknown words carry no operands
  endcase
  return u;
endfunction

// Read-after-write against the last written register
function automatic logic raw_hazard(input uop_t u, input logic [4:0] last_rd);
  return (last_rd != 5'd0) &&
         ((u.use_rs1 && u.rs1 == last_rd) || (u.use_rs2 && u.rs2 == last_rd));
endfunction

`endif

//--- tb/tb_decoder.sv
// Testbench for the decode stage: seeded random instructions checked against a reference model
`timescale 1ns/1ps

module tb_decoder;

  import rv_decode_pkg::*;

  `include "decode_model.svh"

  localparam int NUM_INSTR  = 600;
  localparam int MAX_CYCLES = 2 * NUM_INSTR + 200;  // Worst case with stalls and idle draws

  typedef struct packed {
    logic  is_trap;
    uop_t  uop;
    trap_t trap;
  } expect_t;

  logic                  clk_i;
  logic                  rstn_i;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  instr_valid_i;
  logic                  ready_o;
  logic                  uop_valid_o;
  uop_t                  uop_o;
  logic                  trap_valid_o;
  trap_t                 trap_o;

  expect_t               exp_q[$];
  expect_t               pred;
  logic [REG_ADDR_W-1:0] model_rd;   // Model copy of last_rd
  logic [REG_ADDR_W-1:0] next_rd;
  logic                  pending;    // Output due in this cycle
  logic                  accepted;
  logic                  exp_ready;
  int                    n_accepted;
  int                    n_stalls;
  int                    cycle_count = 0;
  int unsigned           seed;

  rv_decoder_top rv_decoder_top_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .ready_o       (ready_o),
    .uop_valid_o   (uop_valid_o),
    .uop_o         (uop_o),
    .trap_valid_o  (trap_valid_o),
    .trap_o        (trap_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_with_error("Timeout, the decoder did not finish the instruction stream in time");
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Weighted opcodes, registers x0..x3 only so hazards come often
  function automatic logic [XLEN-1:0] random_instr();
    int unsigned pick;
    logic [6:0]  op;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    pick = $urandom % 100;
    f3   = 3'($urandom);
    f7   = 7'($urandom);
    rd   = 5'($urandom % 4);
    rs1  = 5'($urandom % 4);
    rs2  = 5'($urandom % 4);
    if (pick < 22) begin
      op = OPCODE_OP;
      f7 = ($urandom % 2) ? 7'h20 : 7'h00;
    end else if (pick < 44) begin
      op = OPCODE_OPIMM;
      if ((f3 == 3'b001 || f3 == 3'b101) && ($urandom % 8 != 0)) begin
        f7 = ($urandom % 2) ? 7'h20 : 7'h00;  // Mostly legal shifts
      end
    end else if (pick < 52) op = OPCODE_LUI;
    else if (pick < 60) op = OPCODE_AUIPC;
    else if (pick < 72) op = OPCODE_LOAD;
    else if (pick < 82) op = OPCODE_STORE;
    else if (pick < 86) op = OPCODE_MISCMEM;
    else if (pick < 90) return 32'h0000_0073;  // ECALL
    else if (pick < 93) return 32'h0010_0073;  // EBREAK
    else if (pick < 96) return 32'h1050_0073;  // WFI
    else if (pick < 98) op = OPCODE_SYSTEM;
    else op = 7'($urandom);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Output of the beat accepted at the last edge, or nothing
  task automatic check_outputs();
    expect_t e;
    if (!pending) begin
      assert (!uop_valid_o && !trap_valid_o)
      else stop_with_error("An output went valid without an accepted instruction");
    end else begin
      e = exp_q.pop_front();
      assert (uop_valid_o === !e.is_trap)
      else stop_with_error($sformatf("FAIL uop_valid_o expected %h got %h",
                                     !e.is_trap, uop_valid_o));
      assert (trap_valid_o === e.is_trap)
      else stop_with_error($sformatf("FAIL trap_valid_o expected %h got %h",
                                     e.is_trap, trap_valid_o));
      if (e.is_trap) begin
        assert (trap_o === e.trap)
        else stop_with_error($sformatf("FAIL trap_o expected %h got %h", e.trap, trap_o));
      end else begin
        assert (uop_o === e.uop)
        else stop_with_error($sformatf("FAIL uop_o expected %h got %h", e.uop, uop_o));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    seed          = $urandom(32'h495b_c6b6);
    rstn_i        = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    model_rd      = '0;
    next_rd       = '0;
    pending       = 1'b0;
    accepted      = 1'b0;
    n_accepted    = 0;
    n_stalls      = 0;
    repeat (2) @(posedge clk_i);
    #2;
    rstn_i = 1'b1;
    while (n_accepted < NUM_INSTR || pending) begin
      @(posedge clk_i);
      model_rd = next_rd;
      #2;
      if (accepted || !instr_valid_i) begin
        instr_i       = random_instr();
        pc_i          = pc_i + 32'd4;
        // A few idle cycles after reset, then about one empty slot in eight
        instr_valid_i = (n_accepted < NUM_INSTR) && (cycle_count > 5) && ($urandom % 8 != 0);
      end
      @(negedge clk_i);
      check_outputs();
      pred.uop     = uop_for(instr_i, pc_i);
      pred.trap    = trap_for(instr_i);
      pred.is_trap = |pred.trap;
      exp_ready    = !(instr_valid_i && raw_hazard(pred.uop, model_rd));
      assert (ready_o === exp_ready)
      else stop_with_error($sformatf("FAIL ready_o expected %h got %h", exp_ready, ready_o));
      accepted = instr_valid_i && exp_ready;
      pending  = accepted;
      next_rd  = '0;
      if (accepted) begin
        exp_q.push_back(pred);
        n_accepted++;
        if (!pred.is_trap && pred.uop.wb) next_rd = pred.uop.rd;
      end else if (instr_valid_i) begin
        n_stalls++;
      end
    end
    $display("%0d instructions decoded, %0d stall cycles", n_accepted, n_stalls);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- project.f
+incdir+tb
hw/rv_decode_pkg.sv
hw/imm_gen.sv
hw/instr_classifier.sv
hw/hazard_ctrl.sv
hw/pipe_reg.sv
hw/rv_decoder_top.sv
tb/tb_decoder.sv
